/* source/i3c_pkg.sv */
// I3C controller shared definitions
package i3c_pkg;

  // CSR bus geometry
  parameter int unsigned CsrDw = 32;
  parameter int unsigned CsrAw = 4;

  // Default table index widths and SCL divider
  parameter int unsigned DatAwDefault = 4;
  parameter int unsigned DctAwDefault = 3;
  parameter int unsigned ClkDivDefault = 4;

  // Table entry widths
  parameter int unsigned DatWidth = 64;
  parameter int unsigned DctWidth = 128;

  typedef logic [CsrAw-1:0] csr_addr_t;
  typedef logic [CsrDw-1:0] csr_data_t;
  typedef logic [7:0] bus_byte_t;

  // Register map in word addresses
  parameter csr_addr_t CsrStatus = 4'd0;
  parameter csr_addr_t CsrCmd = 4'd1;
  parameter csr_addr_t CsrDatIndex = 4'd2;
  parameter csr_addr_t CsrDatWord0 = 4'd3;
  parameter csr_addr_t CsrDatWord1 = 4'd4;
  parameter csr_addr_t CsrDctIndex = 4'd5;
  parameter csr_addr_t CsrDctWord0 = 4'd6;
  parameter csr_addr_t CsrDctWord1 = 4'd7;
  parameter csr_addr_t CsrDctWord2 = 4'd8;
  parameter csr_addr_t CsrDctWord3 = 4'd9;

  // DAT entry as seen by the engine
  typedef struct packed {
    logic [39:0] rsvd_hi;
    logic        dyn_addr_par;
    logic [6:0]  dyn_addr;
    logic [8:0]  rsvd_lo;
    logic [6:0]  static_addr;
  } dat_entry_t;

  // Same entry as two CSR words with word 0 in the low half
  typedef union packed {
    dat_entry_t           fields;
    csr_data_t [1:0]      words;
  } dat_entry_u;

endpackage

/* source/prim_ram_1p.sv */
// Single-port table memory
`timescale 1ns/1ns

module prim_ram_1p #(
  parameter int unsigned Depth = 16,
  parameter int unsigned Width = 64,
  localparam int unsigned Aw = (Depth > 1) ? $clog2(Depth) : 1,
  localparam int unsigned Lanes = Width / 32
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             req_i,
  input  logic             write_i,
  input  logic [Aw-1:0]    addr_i,
  input  logic [Width-1:0] wdata_i,
  input  logic [Lanes-1:0] wmask_i,
  output logic [Width-1:0] rdata_o
);

  logic [Width-1:0] mem [Depth];

  // Lane-masked write, registered read
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        for (int l = 0; l < Lanes; l++) begin
          if (wmask_i[l]) begin
            mem[addr_i][l*32 +: 32] <= wdata_i[l*32 +: 32];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

  a_addr_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i |-> (!$isunknown(addr_i) && (addr_i < Depth)))
    else $error("Table access with bad address");

endmodule

/* source/i3c_regs.sv */
// I3C register block
`timescale 1ns/1ns

module i3c_regs #(
  parameter int unsigned DatAw = 4,
  parameter int unsigned DctAw = 3
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // CSR bus
  input  logic                              csr_req_i,
  input  logic                              csr_we_i,
  input  i3c_pkg::csr_addr_t                csr_addr_i,
  input  i3c_pkg::csr_data_t                csr_wdata_i,
  output i3c_pkg::csr_data_t                csr_rdata_o,
  output logic                              csr_ack_o,
  // Transfer engine control
  output logic                              xfer_start_o,
  output logic [DatAw-1:0]                  xfer_index_o,
  output i3c_pkg::bus_byte_t                xfer_byte_o,
  input  logic                              xfer_busy_i,
  input  logic                              xfer_end_i,
  input  logic                              xfer_nack_i,
  // Engine side of the DAT port
  input  logic                              eng_dat_req_i,
  input  logic [DatAw-1:0]                  eng_dat_addr_i,
  output logic [i3c_pkg::DatWidth-1:0]      eng_dat_rdata_o,
  // DAT memory
  output logic                              dat_req_o,
  output logic                              dat_write_o,
  output logic [DatAw-1:0]                  dat_addr_o,
  output logic [i3c_pkg::DatWidth-1:0]      dat_wdata_o,
  output logic [i3c_pkg::DatWidth/32-1:0]   dat_wmask_o,
  input  logic [i3c_pkg::DatWidth-1:0]      dat_rdata_i,
  // DCT memory
  output logic                              dct_req_o,
  output logic                              dct_write_o,
  output logic [DctAw-1:0]                  dct_addr_o,
  output logic [i3c_pkg::DctWidth-1:0]      dct_wdata_o,
  output logic [i3c_pkg::DctWidth/32-1:0]   dct_wmask_o,
  input  logic [i3c_pkg::DctWidth-1:0]      dct_rdata_i
);

  logic [DatAw-1:0]    dat_index_q;
  logic [DctAw-1:0]    dct_index_q;
  logic                done_q;
  logic                nack_q;
  logic                is_dat_word;
  logic                is_dct_word;
  logic                start_d;
  logic                plain_ack_q;
  i3c_pkg::csr_data_t  plain_rdata;
  i3c_pkg::csr_data_t  plain_rdata_q;
  // Table access waiting for its memory slot
  logic                tbl_pend_q;
  logic                tbl_ack_q;
  logic                pend_dat_q;
  logic                pend_we_q;
  i3c_pkg::csr_addr_t  pend_addr_q;
  i3c_pkg::csr_data_t  pend_wdata_q;
  logic                sw_dat_go;
  logic                sw_dct_go;
  logic                dat_sel;
  logic [1:0]          dct_sel;
  i3c_pkg::dat_entry_u dat_rd;
  i3c_pkg::csr_data_t  tbl_word;

  assign is_dat_word = (csr_addr_i == i3c_pkg::CsrDatWord0) ||
                       (csr_addr_i == i3c_pkg::CsrDatWord1);
  assign is_dct_word = (csr_addr_i >= i3c_pkg::CsrDctWord0) &&
                       (csr_addr_i <= i3c_pkg::CsrDctWord3);

  // CMD write accepted only with the engine idle
  assign start_d = csr_req_i && csr_we_i && (csr_addr_i == i3c_pkg::CsrCmd) &&
                   !xfer_busy_i && !xfer_start_o;

  always_comb begin
    plain_rdata = '0;
    case (csr_addr_i)
      i3c_pkg::CsrStatus: plain_rdata[2:0] = {nack_q, done_q, xfer_busy_i | xfer_start_o};
      i3c_pkg::CsrCmd: begin
        plain_rdata[7:0] = xfer_byte_o;
        plain_rdata[16 +: DatAw] = xfer_index_o;
      end
      i3c_pkg::CsrDatIndex: plain_rdata = i3c_pkg::csr_data_t'(dat_index_q);
      i3c_pkg::CsrDctIndex: plain_rdata = i3c_pkg::csr_data_t'(dct_index_q);
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dat_index_q  <= '0;
      dct_index_q  <= '0;
      xfer_start_o <= 1'b0;
      xfer_index_o <= '0;
      xfer_byte_o  <= '0;
      done_q       <= 1'b0;
      nack_q       <= 1'b0;
      plain_ack_q  <= 1'b0;
      tbl_pend_q   <= 1'b0;
      tbl_ack_q    <= 1'b0;
    end else begin
      xfer_start_o <= start_d;
      plain_ack_q  <= csr_req_i && !is_dat_word && !is_dct_word;
      tbl_ack_q    <= sw_dat_go || sw_dct_go;
      if (csr_req_i && (is_dat_word || is_dct_word)) begin
        tbl_pend_q <= 1'b1;
      end else if (sw_dat_go || sw_dct_go) begin
        tbl_pend_q <= 1'b0;
      end
      if (csr_req_i && csr_we_i && (csr_addr_i == i3c_pkg::CsrDatIndex)) begin
        dat_index_q <= csr_wdata_i[DatAw-1:0];
      end
      if (csr_req_i && csr_we_i && (csr_addr_i == i3c_pkg::CsrDctIndex)) begin
        dct_index_q <= csr_wdata_i[DctAw-1:0];
      end
      if (start_d) begin
        xfer_index_o <= csr_wdata_i[16 +: DatAw];
        xfer_byte_o  <= csr_wdata_i[7:0];
        done_q       <= 1'b0;
        nack_q       <= 1'b0;
      end else if (xfer_end_i) begin
        done_q <= 1'b1;
        nack_q <= xfer_nack_i;
      end
    end
  end

  // Request payload held until the acknowledge
  always_ff @(posedge clk_i) begin
    if (csr_req_i) begin
      plain_rdata_q <= plain_rdata;
      pend_dat_q    <= is_dat_word;
      pend_we_q     <= csr_we_i;
      pend_addr_q   <= csr_addr_i;
      pend_wdata_q  <= csr_wdata_i;
    end
  end

  // Engine has priority on the DAT port
  assign sw_dat_go = tbl_pend_q && pend_dat_q && !eng_dat_req_i;
  assign sw_dct_go = tbl_pend_q && !pend_dat_q;

  assign dat_sel = (pend_addr_q == i3c_pkg::CsrDatWord1);
  assign dct_sel = 2'(pend_addr_q - i3c_pkg::CsrDctWord0);

  assign dat_req_o       = eng_dat_req_i || sw_dat_go;
  assign dat_write_o     = sw_dat_go && pend_we_q;
  assign dat_addr_o      = eng_dat_req_i ? eng_dat_addr_i : dat_index_q;
  assign dat_wdata_o     = {2{pend_wdata_q}};
  assign dat_wmask_o     = dat_sel ? 2'b10 : 2'b01;
  assign eng_dat_rdata_o = dat_rdata_i;

  assign dct_req_o   = sw_dct_go;
  assign dct_write_o = sw_dct_go && pend_we_q;
  assign dct_addr_o  = dct_index_q;
  assign dct_wdata_o = {4{pend_wdata_q}};
  assign dct_wmask_o = 4'b0001 << dct_sel;

  // Returned word picked from the entry
  assign dat_rd   = dat_rdata_i;
  assign tbl_word = pend_dat_q ? dat_rd.words[dat_sel] : dct_rdata_i[{dct_sel, 5'd0} +: 32];

  assign csr_ack_o   = plain_ack_q || tbl_ack_q;
  assign csr_rdata_o = tbl_ack_q ? tbl_word : plain_rdata_q;

  a_one_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    csr_req_i |-> !(tbl_pend_q || csr_ack_o))
    else $error("CSR request while another is outstanding");

endmodule

/* source/i3c_xfer_engine.sv */
// I3C private write engine
`timescale 1ns/1ns

module i3c_xfer_engine #(
  parameter int unsigned DatAw = 4,
  parameter int unsigned ClkDiv = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         xfer_start_i,
  input  logic [DatAw-1:0]             xfer_index_i,
  input  i3c_pkg::bus_byte_t           xfer_byte_i,
  output logic                         xfer_busy_o,
  output logic                         xfer_end_o,
  output logic                         xfer_nack_o,
  output logic                         dat_req_o,
  output logic [DatAw-1:0]             dat_addr_o,
  input  logic [i3c_pkg::DatWidth-1:0] dat_rdata_i,
  input  logic                         scl_i,
  input  logic                         sda_i,
  output logic                         scl_o,
  output logic                         sda_o,
  output logic                         sel_od_pp_o
);

  localparam int unsigned CntW = (ClkDiv > 1) ? $clog2(ClkDiv) : 1;

  typedef enum logic [2:0] {
    StIdle, StDatReq, StDatWait, StStart, StAddr, StAck, StData, StStop
  } state_e;

  state_e              state_q;
  logic [CntW-1:0]     cnt_q;
  logic                ph_q;
  logic [3:0]          bit_q;
  logic [8:0]          shift_q;
  logic [DatAw-1:0]    idx_q;
  i3c_pkg::bus_byte_t  byte_q;
  logic                nack_q;
  logic                phase_end;
  logic                bit_end;
  logic                ack_ok;
  i3c_pkg::dat_entry_u dat_u;
  logic                scl_d;
  logic                sda_d;
  logic                od_pp_d;
  logic                frame_edge_q;

  assign phase_end = (cnt_q == CntW'(ClkDiv - 1));
  assign bit_end   = phase_end && ph_q;
  // Target pulls SDA low with the SCL line seen high
  assign ack_ok    = scl_i && !sda_i;
  assign dat_u     = dat_rdata_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
      cnt_q   <= '0;
      ph_q    <= 1'b0;
      bit_q   <= '0;
      nack_q  <= 1'b0;
    end else begin
      case (state_q)
        StIdle: if (xfer_start_i) state_q <= StDatReq;
        StDatReq: state_q <= StDatWait;
        StDatWait: begin
          state_q <= StStart;
          cnt_q   <= '0;
          ph_q    <= 1'b0;
          nack_q  <= 1'b0;
        end
        default: begin
          cnt_q <= phase_end ? '0 : cnt_q + 1'b1;
          if (phase_end) ph_q <= ~ph_q;
          if (bit_end) begin
            case (state_q)
              StStart: begin
                state_q <= StAddr;
                bit_q   <= 4'd7;
              end
              StAddr: begin
                if (bit_q == '0) begin
                  state_q <= StAck;
                end else begin
                  bit_q <= bit_q - 1'b1;
                end
              end
              StAck: begin
                state_q <= ack_ok ? StData : StStop;
                nack_q  <= !ack_ok;
                bit_q   <= 4'd8;
              end
              StData: begin
                if (bit_q == '0) begin
                  state_q <= StStop;
                end else begin
                  bit_q <= bit_q - 1'b1;
                end
              end
              default: state_q <= StIdle;
            endcase
          end
        end
      endcase
    end
  end

  // Captured command and outgoing shift register
  always_ff @(posedge clk_i) begin
    if (xfer_start_i && (state_q == StIdle)) begin
      idx_q  <= xfer_index_i;
      byte_q <= xfer_byte_i;
    end
    if (state_q == StDatWait) begin
      shift_q <= {dat_u.fields.dyn_addr, 1'b0, 1'b0};
    end else if (bit_end && (state_q == StAck)) begin
      // T bit makes the total count of ones odd
      shift_q <= {byte_q, ~^byte_q};
    end else if (bit_end && ((state_q == StAddr) || (state_q == StData))) begin
      shift_q <= shift_q << 1;
    end
  end

  always_comb begin
    scl_d   = 1'b1;
    sda_d   = 1'b1;
    od_pp_d = 1'b0;
    case (state_q)
      StStart: sda_d = ~ph_q;
      StAddr, StAck, StData, StStop: begin
        scl_d   = ph_q;
        od_pp_d = (state_q == StData);
        if (!ph_q && (cnt_q == '0)) begin
          // Hold SDA for the cycle in which SCL falls
          sda_d = sda_o;
        end else if (state_q == StAck) begin
          sda_d = 1'b1;
        end else if (state_q == StStop) begin
          sda_d = 1'b0;
        end else begin
          sda_d = shift_q[8];
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_o        <= 1'b1;
      sda_o        <= 1'b1;
      sel_od_pp_o  <= 1'b0;
      frame_edge_q <= 1'b1;
    end else begin
      scl_o        <= scl_d;
      sda_o        <= sda_d;
      sel_od_pp_o  <= od_pp_d;
      frame_edge_q <= (state_q == StStart) || (state_q == StIdle);
    end
  end

  assign xfer_busy_o = (state_q != StIdle);
  // End pulse in the last STOP cycle
  assign xfer_end_o  = (state_q == StStop) && bit_end;
  assign xfer_nack_o = nack_q;
  assign dat_req_o   = (state_q == StDatReq);
  assign dat_addr_o  = idx_q;

  // SDA moves under a high SCL only for START and STOP
  a_sda_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($changed(sda_o) && scl_o && $past(scl_o)) |-> frame_edge_q)
    else $error("SDA changed while SCL high outside START/STOP");

endmodule

/* source/i3c_wrapper.sv */
// I3C controller top level
`timescale 1ns/1ns

module i3c_wrapper #(
  parameter int unsigned DatAw = i3c_pkg::DatAwDefault,
  parameter int unsigned DctAw = i3c_pkg::DctAwDefault,
  parameter int unsigned ClkDiv = i3c_pkg::ClkDivDefault
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               csr_req_i,
  input  logic               csr_we_i,
  input  i3c_pkg::csr_addr_t csr_addr_i,
  input  i3c_pkg::csr_data_t csr_wdata_i,
  output i3c_pkg::csr_data_t csr_rdata_o,
  output logic               csr_ack_o,
  input  logic               scl_i,
  input  logic               sda_i,
  output logic               scl_o,
  output logic               sda_o,
  output logic               sel_od_pp_o
);

  logic                              xfer_start;
  logic [DatAw-1:0]                  xfer_index;
  i3c_pkg::bus_byte_t                xfer_byte;
  logic                              xfer_busy;
  logic                              xfer_end;
  logic                              xfer_nack;
  logic                              eng_dat_req;
  logic [DatAw-1:0]                  eng_dat_addr;
  logic [i3c_pkg::DatWidth-1:0]      eng_dat_rdata;
  logic                              dat_req;
  logic                              dat_write;
  logic [DatAw-1:0]                  dat_addr;
  logic [i3c_pkg::DatWidth-1:0]      dat_wdata;
  logic [i3c_pkg::DatWidth/32-1:0]   dat_wmask;
  logic [i3c_pkg::DatWidth-1:0]      dat_rdata;
  logic                              dct_req;
  logic                              dct_write;
  logic [DctAw-1:0]                  dct_addr;
  logic [i3c_pkg::DctWidth-1:0]      dct_wdata;
  logic [i3c_pkg::DctWidth/32-1:0]   dct_wmask;
  logic [i3c_pkg::DctWidth-1:0]      dct_rdata;

  i3c_regs #(
    .DatAw(DatAw),
    .DctAw(DctAw)
  ) i_i3c_regs (
    .clk_i,
    .rst_n_i,
    .csr_req_i,
    .csr_we_i,
    .csr_addr_i,
    .csr_wdata_i,
    .csr_rdata_o,
    .csr_ack_o,
    .xfer_start_o   (xfer_start),
    .xfer_index_o   (xfer_index),
    .xfer_byte_o    (xfer_byte),
    .xfer_busy_i    (xfer_busy),
    .xfer_end_i     (xfer_end),
    .xfer_nack_i    (xfer_nack),
    .eng_dat_req_i  (eng_dat_req),
    .eng_dat_addr_i (eng_dat_addr),
    .eng_dat_rdata_o(eng_dat_rdata),
    .dat_req_o      (dat_req),
    .dat_write_o    (dat_write),
    .dat_addr_o     (dat_addr),
    .dat_wdata_o    (dat_wdata),
    .dat_wmask_o    (dat_wmask),
    .dat_rdata_i    (dat_rdata),
    .dct_req_o      (dct_req),
    .dct_write_o    (dct_write),
    .dct_addr_o     (dct_addr),
    .dct_wdata_o    (dct_wdata),
    .dct_wmask_o    (dct_wmask),
    .dct_rdata_i    (dct_rdata)
  );

  i3c_xfer_engine #(
    .DatAw (DatAw),
    .ClkDiv(ClkDiv)
  ) i_i3c_xfer_engine (
    .clk_i,
    .rst_n_i,
    .xfer_start_i(xfer_start),
    .xfer_index_i(xfer_index),
    .xfer_byte_i (xfer_byte),
    .xfer_busy_o (xfer_busy),
    .xfer_end_o  (xfer_end),
    .xfer_nack_o (xfer_nack),
    .dat_req_o   (eng_dat_req),
    .dat_addr_o  (eng_dat_addr),
    .dat_rdata_i (eng_dat_rdata),
    .scl_i,
    .sda_i,
    .scl_o,
    .sda_o,
    .sel_od_pp_o
  );

  prim_ram_1p #(
    .Depth(2 ** DatAw),
    .Width(i3c_pkg::DatWidth)
  ) dat_memory (
    .clk_i,
    .rst_n_i,
    .req_i  (dat_req),
    .write_i(dat_write),
    .addr_i (dat_addr),
    .wdata_i(dat_wdata),
    .wmask_i(dat_wmask),
    .rdata_o(dat_rdata)
  );

  prim_ram_1p #(
    .Depth(2 ** DctAw),
    .Width(i3c_pkg::DctWidth)
  ) dct_memory (
    .clk_i,
    .rst_n_i,
    .req_i  (dct_req),
    .write_i(dct_write),
    .addr_i (dct_addr),
    .wdata_i(dct_wdata),
    .wmask_i(dct_wmask),
    .rdata_o(dct_rdata)
  );

endmodule

/* dv/tb_i3c_wrapper.sv */
// I3C controller directed testbench
`timescale 1ns/1ns

module tb_i3c_wrapper;

  localparam int unsigned DatAw = i3c_pkg::DatAwDefault;
  localparam int unsigned DctAw = i3c_pkg::DctAwDefault;
  localparam int unsigned ClkDiv = i3c_pkg::ClkDivDefault;
  localparam int AckTimeout = 20;
  localparam int IdlePolls = 200;

  logic               clk;
  logic               rst_n;
  logic               csr_req;
  logic               csr_we;
  i3c_pkg::csr_addr_t csr_addr;
  i3c_pkg::csr_data_t csr_wdata;
  i3c_pkg::csr_data_t csr_rdata;
  logic               csr_ack;
  logic               scl;
  logic               sda;
  logic               sda_line;
  logic               sel_od_pp;

  // Target model
  logic ack_en = 1'b0;
  logic sda_pull = 1'b0;
  logic frame_bits[$];
  logic od_bits[$];
  int   start_cnt = 0;
  int   stop_cnt = 0;
  int   starts_ref;
  int   stops_ref;

  int                 seed;
  i3c_pkg::csr_data_t dat_model [2**DatAw][2];
  logic               dat_used [2**DatAw];
  i3c_pkg::csr_data_t dct_model [2**DctAw][4];

  i3c_wrapper #(
    .DatAw (DatAw),
    .DctAw (DctAw),
    .ClkDiv(ClkDiv)
  ) i_i3c_wrapper (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .csr_req_i  (csr_req),
    .csr_we_i   (csr_we),
    .csr_addr_i (csr_addr),
    .csr_wdata_i(csr_wdata),
    .csr_rdata_o(csr_rdata),
    .csr_ack_o  (csr_ack),
    .scl_i      (scl),
    .sda_i      (sda_line),
    .scl_o      (scl),
    .sda_o      (sda),
    .sel_od_pp_o(sel_od_pp)
  );

  // Open-drain SDA where the target can only pull low
  assign sda_line = sda & ~sda_pull;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // START and STOP are SDA edges under a high SCL
  always @(negedge sda_line) begin
    if (scl === 1'b1) begin
      frame_bits.delete();
      od_bits.delete();
      start_cnt++;
    end
  end

  always @(posedge sda_line) begin
    if (scl === 1'b1) begin
      stop_cnt++;
    end
  end

  always @(posedge scl) begin
    frame_bits.push_back(sda_line);
    od_bits.push_back(sel_od_pp);
  end

  // Pull SDA low through the ninth clock for the ACK
  always @(negedge scl) begin
    sda_pull <= ack_en && (frame_bits.size() == 8);
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "Run aborted");
  endtask

  task automatic check_csr(input string what, input i3c_pkg::csr_data_t got,
                           input i3c_pkg::csr_data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t ns: %s got %h expected %h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_byte(input string what, input i3c_pkg::bus_byte_t got,
                            input i3c_pkg::bus_byte_t exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t ns: %s got %h expected %h",
                          $time, what, got, exp));
    end
  endtask

  task automatic csr_access(input logic we, input i3c_pkg::csr_addr_t addr,
                            input i3c_pkg::csr_data_t wdata,
                            output i3c_pkg::csr_data_t rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    csr_req   <= 1'b1;
    csr_we    <= we;
    csr_addr  <= addr;
    csr_wdata <= wdata;
    @(posedge clk);
    csr_req <= 1'b0;
    @(negedge clk);
    while (csr_ack !== 1'b1) begin
      waited++;
      if (waited > AckTimeout) begin
        abort_run($sformatf("No CSR acknowledge for address %0d after %0d cycles",
                            addr, AckTimeout));
      end
      @(negedge clk);
    end
    rdata = csr_rdata;
  endtask

  task automatic csr_write(input i3c_pkg::csr_addr_t addr, input i3c_pkg::csr_data_t data);
    i3c_pkg::csr_data_t unused;
    csr_access(1'b1, addr, data, unused);
  endtask

  task automatic csr_read(input i3c_pkg::csr_addr_t addr, output i3c_pkg::csr_data_t data);
    csr_access(1'b0, addr, '0, data);
  endtask

  // Poll STATUS until busy drops
  task automatic wait_idle(output i3c_pkg::csr_data_t status);
    int polls;
    polls = 0;
    csr_read(i3c_pkg::CsrStatus, status);
    while (status[0] !== 1'b0) begin
      polls++;
      if (polls > IdlePolls) begin
        abort_run("Transfer still busy after the polling limit");
      end
      csr_read(i3c_pkg::CsrStatus, status);
    end
  endtask

  task automatic dat_write(input int idx, input int word, input i3c_pkg::csr_data_t value);
    csr_write(i3c_pkg::CsrDatIndex, i3c_pkg::csr_data_t'(idx));
    csr_write((word == 0) ? i3c_pkg::CsrDatWord0 : i3c_pkg::CsrDatWord1, value);
    dat_model[idx][word] = value;
    dat_used[idx] = 1'b1;
  endtask

  task automatic dat_check(input int idx);
    i3c_pkg::csr_data_t got;
    csr_write(i3c_pkg::CsrDatIndex, i3c_pkg::csr_data_t'(idx));
    csr_read(i3c_pkg::CsrDatWord0, got);
    check_csr($sformatf("DAT[%0d] word 0", idx), got, dat_model[idx][0]);
    csr_read(i3c_pkg::CsrDatWord1, got);
    check_csr($sformatf("DAT[%0d] word 1", idx), got, dat_model[idx][1]);
  endtask

  task automatic dat_check_all();
    for (int i = 0; i < 2**DatAw; i++) begin
      if (dat_used[i]) begin
        dat_check(i);
      end
    end
  endtask

  // DAT entry with a dynamic address and a random word 1
  task automatic dat_program(input int idx, input logic [6:0] dyn, input logic [6:0] stat);
    dat_write(idx, 0, {8'h00, ~^dyn, dyn, 9'h000, stat});
    dat_write(idx, 1, $random(seed));
  endtask

  function automatic i3c_pkg::bus_byte_t pack_byte(input logic q[$], input int first);
    i3c_pkg::bus_byte_t b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      b = {b[6:0], q[first + i]};
    end
    return b;
  endfunction

  task automatic start_private_write(input int idx, input i3c_pkg::bus_byte_t data,
                                     input logic acked);
    ack_en     <= acked;
    starts_ref = start_cnt;
    stops_ref  = stop_cnt;
    csr_write(i3c_pkg::CsrCmd, {8'h00, 8'(idx), 8'h00, data});
  endtask

  task automatic check_frame(input logic [6:0] dyn, input i3c_pkg::bus_byte_t data,
                             input logic acked);
    int nbits;
    nbits = frame_bits.size();
    check_csr("START conditions", i3c_pkg::csr_data_t'(start_cnt - starts_ref), 32'd1);
    check_csr("STOP conditions", i3c_pkg::csr_data_t'(stop_cnt - stops_ref), 32'd1);
    // Address, RnW and ACK, then data and T, then the STOP clock
    check_csr("SCL pulses in frame", i3c_pkg::csr_data_t'(nbits), acked ? 32'd19 : 32'd10);
    check_byte("address with RnW", pack_byte(frame_bits, 0), {dyn, 1'b0});
    check_byte("ACK slot", {7'b0, frame_bits[8]}, {7'b0, !acked});
    check_byte("push-pull in address", pack_byte(od_bits, 0), 8'h00);
    check_byte("push-pull in ACK slot", {7'b0, od_bits[8]}, 8'h00);
    if (acked) begin
      check_byte("data byte", pack_byte(frame_bits, 9), data);
      // Odd parity means T is set when the byte has an even number of ones
      check_byte("T bit", {7'b0, frame_bits[17]}, {7'b0, ($countones(data) % 2) == 0});
      check_byte("push-pull in data", pack_byte(od_bits, 9), 8'hff);
      check_byte("push-pull in T bit", {7'b0, od_bits[17]}, 8'h01);
    end
    check_byte("SDA low before STOP", {7'b0, frame_bits[nbits-1]}, 8'h00);
  endtask

  task automatic test_reset_state();
    i3c_pkg::csr_data_t status;
    @(negedge clk);
    check_byte("SCL, SDA, mode after reset", {5'b0, scl, sda, sel_od_pp}, 8'b0000_0110);
    check_byte("CSR ack after reset", {7'b0, csr_ack}, 8'h00);
    csr_read(i3c_pkg::CsrStatus, status);
    check_csr("STATUS after reset", status, 32'h0);
  endtask

  task automatic test_dat_access();
    int idx_list[4] = '{1, 5, 9, 14};
    foreach (idx_list[i]) begin
      dat_write(idx_list[i], 0, $random(seed));
      dat_write(idx_list[i], 1, $random(seed));
    end
    dat_check_all();
    // Single word updates leave the other half alone
    dat_write(5, 0, $random(seed));
    dat_check(5);
    dat_write(9, 1, $random(seed));
    dat_check(9);
  endtask

  task automatic test_dct_access();
    int idx_list[3] = '{0, 3, 7};
    i3c_pkg::csr_data_t got;
    foreach (idx_list[i]) begin
      csr_write(i3c_pkg::CsrDctIndex, i3c_pkg::csr_data_t'(idx_list[i]));
      for (int w = 0; w < 4; w++) begin
        dct_model[idx_list[i]][w] = $random(seed);
        csr_write(i3c_pkg::csr_addr_t'(i3c_pkg::CsrDctWord0 + w), dct_model[idx_list[i]][w]);
      end
    end
    foreach (idx_list[i]) begin
      csr_write(i3c_pkg::CsrDctIndex, i3c_pkg::csr_data_t'(idx_list[i]));
      for (int w = 0; w < 4; w++) begin
        csr_read(i3c_pkg::csr_addr_t'(i3c_pkg::CsrDctWord0 + w), got);
        check_csr($sformatf("DCT[%0d] word %0d", idx_list[i], w), got,
                  dct_model[idx_list[i]][w]);
      end
    end
    dat_check_all();
  endtask

  task automatic test_write_acked();
    i3c_pkg::bus_byte_t data;
    i3c_pkg::csr_data_t status;
    data = 8'($random(seed));
    dat_program(3, 7'h52, 7'h11);
    start_private_write(3, data, 1'b1);
    wait_idle(status);
    check_csr("STATUS after acked write", status, 32'h2);
    check_frame(7'h52, data, 1'b1);
  endtask

  task automatic test_write_nacked();
    i3c_pkg::bus_byte_t data;
    i3c_pkg::csr_data_t status;
    data = 8'($random(seed));
    dat_program(10, 7'h2c, 7'h20);
    start_private_write(10, data, 1'b0);
    wait_idle(status);
    check_csr("STATUS after NACK", status, 32'h6);
    check_frame(7'h2c, data, 1'b0);
  endtask

  task automatic test_dat_read_busy();
    i3c_pkg::bus_byte_t data;
    i3c_pkg::csr_data_t status;
    data = 8'($random(seed));
    dat_program(7, 7'h3a, 7'h08);
    start_private_write(7, data, 1'b1);
    csr_read(i3c_pkg::CsrStatus, status);
    check_csr("STATUS busy during transfer", status & 32'h1, 32'h1);
    dat_check(7);
    dat_check(14);
    wait_idle(status);
    check_csr("STATUS after busy-time reads", status, 32'h2);
    check_frame(7'h3a, data, 1'b1);
  endtask

  initial begin
    seed      = 32'hea30_7f09;
    rst_n     = 1'b0;
    csr_req   = 1'b0;
    csr_we    = 1'b0;
    csr_addr  = '0;
    csr_wdata = '0;
    foreach (dat_used[i]) begin
      dat_used[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_dat_access();
    test_dct_access();
    test_write_acked();
    test_write_nacked();
    test_dat_read_busy();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* sources.f */
source/i3c_pkg.sv
source/prim_ram_1p.sv
source/i3c_regs.sv
source/i3c_xfer_engine.sv
source/i3c_wrapper.sv
dv/tb_i3c_wrapper.sv

/* Makefile */
TOOL      := verilator
TOP       := tb_i3c_wrapper
RTL_TOP   := i3c_wrapper
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
